// ==== common/long_pipe_cfg.svh ====
`ifndef LONG_PIPE_CFG_SVH
`define LONG_PIPE_CFG_SVH

// datapath and register file sizes.
`define LP_XLEN 32
`define LP_REG_ADDR_W 5

`define LP_OP_W 3 // long-op code width.

// one product or quotient bit per cycle.
`define LP_ITERS `LP_XLEN

`endif

// ==== common/long_pipe_pkg.sv ====
`include "long_pipe_cfg.svh"

package long_pipe_pkg;

  typedef logic [`LP_XLEN-1:0] xword_t;
  typedef logic [`LP_REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [`LP_OP_W-1:0] {
    e_op_mulh,
    e_op_mulhsu,
    e_op_mulhu,
    e_op_div,
    e_op_divu,
    e_op_rem,
    e_op_remu
  } long_op_e;

  // e_wb holds the result until yumi.
  typedef enum logic [1:0] {
    e_idle,
    e_mul,
    e_div,
    e_wb
  } ctrl_state_e;

  typedef struct packed {
    logic      v;
    long_op_e  op;
    reg_addr_t rd_addr;
    xword_t    src1;
    xword_t    src2;
  } reservation_s;

  typedef struct packed {
    logic      rd_w_v;
    reg_addr_t rd_addr;
    xword_t    rd_data;
  } wb_pkt_s;

endpackage

// ==== verilog/long_pipe_ctrl.sv ====
`timescale 1ns/1ns

module long_pipe_ctrl (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  long_pipe_pkg::reservation_s  reservation_i,
  input  logic                         flush_i,
  input  logic                         wb_yumi_i,
  output logic                         busy_o,
  output logic                         wb_v_o,
  output long_pipe_pkg::wb_pkt_s       wb_pkt_o,
  output logic                         mul_start_o,
  output logic                         div_start_o,
  output long_pipe_pkg::xword_t        opa_o,
  output long_pipe_pkg::xword_t        opb_o,
  output logic                         signed_a_o,
  output logic                         signed_b_o,
  output logic                         kill_o,
  input  logic                         mul_done_i,
  input  long_pipe_pkg::xword_t        mul_result_i,
  input  logic                         div_done_i,
  input  long_pipe_pkg::xword_t        quotient_i,
  input  long_pipe_pkg::xword_t        remainder_i
);

  long_pipe_pkg::ctrl_state_e state_r;
  long_pipe_pkg::ctrl_state_e state_n;
  long_pipe_pkg::long_op_e    op_r;
  long_pipe_pkg::reg_addr_t   rd_addr_r;
  long_pipe_pkg::xword_t      wb_data_r;
  long_pipe_pkg::xword_t      result_sel;
  logic                       accept;
  logic                       is_mul;
  logic                       capture;

  assign is_mul = reservation_i.op inside {long_pipe_pkg::e_op_mulh,
                                           long_pipe_pkg::e_op_mulhsu,
                                           long_pipe_pkg::e_op_mulhu};

  // a flush also drops a reservation arriving in the same cycle.
  assign accept = reservation_i.v & (state_r == long_pipe_pkg::e_idle) & ~flush_i;

  assign signed_a_o = reservation_i.op inside {long_pipe_pkg::e_op_mulh,
                                               long_pipe_pkg::e_op_mulhsu,
                                               long_pipe_pkg::e_op_div,
                                               long_pipe_pkg::e_op_rem};
  assign signed_b_o = reservation_i.op inside {long_pipe_pkg::e_op_mulh,
                                               long_pipe_pkg::e_op_div,
                                               long_pipe_pkg::e_op_rem};

  assign opa_o       = reservation_i.src1; // units latch on start.
  assign opb_o       = reservation_i.src2;
  assign mul_start_o = accept & is_mul;
  assign div_start_o = accept & ~is_mul;

  assign busy_o = reservation_i.v | (state_r != long_pipe_pkg::e_idle);
  assign kill_o = flush_i & busy_o;

  always_comb begin
    case (op_r)
      long_pipe_pkg::e_op_div, long_pipe_pkg::e_op_divu: result_sel = quotient_i;
      long_pipe_pkg::e_op_rem, long_pipe_pkg::e_op_remu: result_sel = remainder_i;
      default: result_sel = mul_result_i; // mulh variants.
    endcase
  end

  assign capture = ((state_r == long_pipe_pkg::e_mul) & mul_done_i) |
                   ((state_r == long_pipe_pkg::e_div) & div_done_i);

  always_comb begin
    state_n = state_r;
    case (state_r)
      long_pipe_pkg::e_idle: begin
        if (accept) state_n = is_mul ? long_pipe_pkg::e_mul : long_pipe_pkg::e_div;
      end
      long_pipe_pkg::e_mul: begin
        if (mul_done_i) state_n = long_pipe_pkg::e_wb;
      end
      long_pipe_pkg::e_div: begin
        if (div_done_i) state_n = long_pipe_pkg::e_wb;
      end
      long_pipe_pkg::e_wb: begin
        if (wb_yumi_i) state_n = long_pipe_pkg::e_idle;
      end
      default: state_n = long_pipe_pkg::e_idle;
    endcase
    if (flush_i) state_n = long_pipe_pkg::e_idle;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= long_pipe_pkg::e_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r      <= reservation_i.op;
      rd_addr_r <= reservation_i.rd_addr;
    end
    if (capture) wb_data_r <= result_sel;
  end

  assign wb_v_o = (state_r == long_pipe_pkg::e_wb) & ~flush_i;

  assign wb_pkt_o = '{rd_w_v: wb_v_o, rd_addr: rd_addr_r, rd_data: wb_data_r};

  // consumer only takes a packet that is offered.
  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (wb_yumi_i && !flush_i) |-> wb_v_o);

  // issue stage honours busy.
  no_issue_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    reservation_i.v |-> (state_r == long_pipe_pkg::e_idle));

  // done must come from the unit running the op.
  mul_done_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mul_done_i |-> (state_r == long_pipe_pkg::e_mul));
  div_done_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    div_done_i |-> (state_r == long_pipe_pkg::e_div));

endmodule

// ==== muldiv/imul_iterative.sv ====
`timescale 1ns/1ns
`include "long_pipe_cfg.svh"

module imul_iterative (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  kill_i,
  input  logic                  start_i,
  input  long_pipe_pkg::xword_t opa_i,
  input  long_pipe_pkg::xword_t opb_i,
  input  logic                  signed_a_i,
  input  logic                  signed_b_i,
  output logic                  done_o,
  output long_pipe_pkg::xword_t result_o
);

  localparam int cnt_w_lp = $clog2(`LP_ITERS);

  logic                        busy_r;
  logic                        done_r;
  logic                        neg_r;
  logic [cnt_w_lp-1:0]         cnt_r;
  logic [2*`LP_XLEN-1:0]       mcand_r;
  logic [2*`LP_XLEN-1:0]       prod_r;
  logic [2*`LP_XLEN-1:0]       prod_sum;
  logic [2*`LP_XLEN-1:0]       prod_fin;
  long_pipe_pkg::xword_t       mplr_r;
  long_pipe_pkg::xword_t       result_r;
  long_pipe_pkg::xword_t       mag_a;
  long_pipe_pkg::xword_t       mag_b;
  logic                        neg_a;
  logic                        neg_b;

  assign neg_a = signed_a_i & opa_i[`LP_XLEN-1];
  assign neg_b = signed_b_i & opb_i[`LP_XLEN-1];
  assign mag_a = neg_a ? -opa_i : opa_i;
  assign mag_b = neg_b ? -opb_i : opb_i; // most negative maps to 2**(xlen-1).

  assign prod_sum = prod_r + (mplr_r[0] ? mcand_r : '0);
  assign prod_fin = neg_r ? -prod_sum : prod_sum;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
      cnt_r  <= '0;
    end else if (kill_i) begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end else begin
      done_r <= 1'b0;
      if (start_i) begin
        busy_r <= 1'b1;
        cnt_r  <= '0;
      end else if (busy_r) begin
        cnt_r <= cnt_r + 1'b1;
        if (cnt_r == cnt_w_lp'(`LP_ITERS-1)) begin
          busy_r <= 1'b0;
          done_r <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      neg_r   <= neg_a ^ neg_b;
      mcand_r <= {{`LP_XLEN{1'b0}}, mag_a};
      mplr_r  <= mag_b;
      prod_r  <= '0;
    end else if (busy_r) begin
      prod_r   <= prod_sum;
      mcand_r  <= mcand_r << 1;
      mplr_r   <= mplr_r >> 1;
      result_r <= prod_fin[2*`LP_XLEN-1:`LP_XLEN]; // final on the last step.
    end
  end

  assign done_o   = done_r;
  assign result_o = result_r;

  no_start_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_i |-> !busy_r);

endmodule

// ==== muldiv/idiv_iterative.sv ====
`timescale 1ns/1ns
`include "long_pipe_cfg.svh"

module idiv_iterative (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  kill_i,
  input  logic                  start_i,
  input  long_pipe_pkg::xword_t dividend_i,
  input  long_pipe_pkg::xword_t divisor_i,
  input  logic                  signed_i,
  output logic                  done_o,
  output long_pipe_pkg::xword_t quotient_o,
  output long_pipe_pkg::xword_t remainder_o
);

  localparam int cnt_w_lp = $clog2(`LP_ITERS);

  typedef enum logic [1:0] {
    e_div_idle,
    e_div_run,
    e_div_fix
  } div_state_e;

  div_state_e            state_r;
  logic [cnt_w_lp-1:0]   cnt_r;
  logic                  done_r;
  logic                  neg_q_r;
  logic                  neg_rem_r;
  long_pipe_pkg::xword_t dvsr_r;
  long_pipe_pkg::xword_t quot_r;
  long_pipe_pkg::xword_t rem_r;
  long_pipe_pkg::xword_t quotient_r;
  long_pipe_pkg::xword_t remainder_r;
  long_pipe_pkg::xword_t mag_n;
  long_pipe_pkg::xword_t mag_d;
  logic [`LP_XLEN:0]     shifted;
  logic [`LP_XLEN:0]     diff;
  logic                  neg_n;
  logic                  neg_d;
  logic                  div_zero;
  logic                  overflow;

  assign neg_n = signed_i & dividend_i[`LP_XLEN-1];
  assign neg_d = signed_i & divisor_i[`LP_XLEN-1];
  assign mag_n = neg_n ? -dividend_i : dividend_i;
  assign mag_d = neg_d ? -divisor_i : divisor_i;

  assign div_zero = (divisor_i == '0);
  assign overflow = signed_i & (dividend_i == {1'b1, {(`LP_XLEN-1){1'b0}}}) &
                    (divisor_i == '1);

  // partial remainder with the next dividend bit shifted in.
  assign shifted = {rem_r, quot_r[`LP_XLEN-1]};
  assign diff    = shifted - {1'b0, dvsr_r}; // msb set means no subtract.

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= e_div_idle;
      cnt_r   <= '0;
      done_r  <= 1'b0;
    end else if (kill_i) begin
      state_r <= e_div_idle;
      done_r  <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state_r)
        e_div_idle: begin
          if (start_i && (div_zero || overflow)) begin
            done_r <= 1'b1; // special cases finish at once.
          end else if (start_i) begin
            state_r <= e_div_run;
            cnt_r   <= '0;
          end
        end
        e_div_run: begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_w_lp'(`LP_ITERS-1)) state_r <= e_div_fix;
        end
        default: begin
          state_r <= e_div_idle;
          done_r  <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      if (div_zero) begin
        quotient_r  <= '1;
        remainder_r <= dividend_i;
      end else if (overflow) begin
        quotient_r  <= dividend_i;
        remainder_r <= '0;
      end
      dvsr_r    <= mag_d;
      quot_r    <= mag_n;
      rem_r     <= '0;
      neg_q_r   <= neg_n ^ neg_d;
      neg_rem_r <= neg_n; // remainder follows the dividend.
    end else if (state_r == e_div_run) begin
      rem_r  <= diff[`LP_XLEN] ? shifted[`LP_XLEN-1:0] : diff[`LP_XLEN-1:0];
      quot_r <= {quot_r[`LP_XLEN-2:0], ~diff[`LP_XLEN]};
    end else if (state_r == e_div_fix) begin
      quotient_r  <= neg_q_r ? -quot_r : quot_r;
      remainder_r <= neg_rem_r ? -rem_r : rem_r;
    end
  end

  assign done_o      = done_r;
  assign quotient_o  = quotient_r;
  assign remainder_o = remainder_r;

  no_start_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_i |-> (state_r == e_div_idle));

endmodule

// ==== verilog/long_pipe_top.sv ====
`timescale 1ns/1ns

module long_pipe_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  long_pipe_pkg::reservation_s reservation_i,
  input  logic                        flush_i,
  input  logic                        wb_yumi_i,
  output logic                        busy_o,
  output logic                        wb_v_o,
  output long_pipe_pkg::wb_pkt_s      wb_pkt_o
);

  logic                  mul_start;
  logic                  div_start;
  logic                  signed_a;
  logic                  signed_b;
  logic                  kill;
  logic                  mul_done;
  logic                  div_done;
  long_pipe_pkg::xword_t opa;
  long_pipe_pkg::xword_t opb;
  long_pipe_pkg::xword_t mul_result;
  long_pipe_pkg::xword_t quotient;
  long_pipe_pkg::xword_t remainder;

  long_pipe_ctrl u_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .reservation_i (reservation_i),
    .flush_i       (flush_i),
    .wb_yumi_i     (wb_yumi_i),
    .busy_o        (busy_o),
    .wb_v_o        (wb_v_o),
    .wb_pkt_o      (wb_pkt_o),
    .mul_start_o   (mul_start),
    .div_start_o   (div_start),
    .opa_o         (opa),
    .opb_o         (opb),
    .signed_a_o    (signed_a),
    .signed_b_o    (signed_b),
    .kill_o        (kill),
    .mul_done_i    (mul_done),
    .mul_result_i  (mul_result),
    .div_done_i    (div_done),
    .quotient_i    (quotient),
    .remainder_i   (remainder)
  );

  imul_iterative u_imul (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .kill_i     (kill),
    .start_i    (mul_start),
    .opa_i      (opa),
    .opb_i      (opb),
    .signed_a_i (signed_a),
    .signed_b_i (signed_b),
    .done_o     (mul_done),
    .result_o   (mul_result)
  );

  // div and rem have equal operand signedness.
  idiv_iterative u_idiv (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .kill_i      (kill),
    .start_i     (div_start),
    .dividend_i  (opa),
    .divisor_i   (opb),
    .signed_i    (signed_a),
    .done_o      (div_done),
    .quotient_o  (quotient),
    .remainder_o (remainder)
  );

endmodule

// ==== dv/long_pipe_tb.sv ====
`timescale 1ns/1ns
`include "long_pipe_cfg.svh"

module long_pipe_tb;

  typedef struct packed {
    long_pipe_pkg::long_op_e  op;
    long_pipe_pkg::reg_addr_t rd_addr;
    long_pipe_pkg::xword_t    src1;
    long_pipe_pkg::xword_t    src2;
    logic [7:0]               flush_dly;
    long_pipe_pkg::xword_t    exp_data;
  } vector_s;

  logic                        clk;
  logic                        arst_n;
  long_pipe_pkg::reservation_s reservation;
  logic                        flush;
  logic                        wb_yumi;
  logic                        busy;
  logic                        wb_v;
  long_pipe_pkg::wb_pkt_s      wb_pkt;

  vector_s     vectors[$];
  logic [31:0] lfsr;

  long_pipe_top dut_i (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .reservation_i (reservation),
    .flush_i       (flush),
    .wb_yumi_i     (wb_yumi),
    .busy_o        (busy),
    .wb_v_o        (wb_v),
    .wb_pkt_o      (wb_pkt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois form with taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  task automatic draw_yumi_delay(output logic [1:0] dly);
    int i;
    for (i = 0; i < 2; i++) begin
      lfsr   = lfsr_step(lfsr);
      dly[i] = lfsr[0];
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_rd;
    logic [31:0] f_src1;
    logic [31:0] f_src2;
    logic [31:0] f_flush;
    logic [31:0] f_exp;
    vector_s     vec;
    fd = $fopen("dv/long_pipe_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file dv/long_pipe_input.txt");
      $display("Done: errors found");
      $fatal(1, "no stimulus");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        fields = $sscanf(line, "%h %h %h %h %h %h",
                         f_op, f_rd, f_src1, f_src2, f_flush, f_exp);
        if (fields == 6) begin // comment lines do not parse.
          vec.op        = long_pipe_pkg::long_op_e'(f_op[2:0]);
          vec.rd_addr   = f_rd[`LP_REG_ADDR_W-1:0];
          vec.src1      = f_src1;
          vec.src2      = f_src2;
          vec.flush_dly = f_flush[7:0];
          vec.exp_data  = f_exp;
          vectors.push_back(vec);
        end
      end
      $fclose(fd);
      if (vectors.size() == 0) begin
        $display("the vector file holds no vectors");
        $display("Done: errors found");
        $fatal(1, "no stimulus");
      end
    end
  endtask

  task automatic watchdog();
    int unsigned limit;
    limit = vectors.size() * (`LP_ITERS + 10) + 16;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, the long pipe hung", limit);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  endtask

  task automatic wait_for_flush(input vector_s vec);
    int i;
    for (i = 0; i < vec.flush_dly; i++) begin
      @(negedge clk);
      check_value("wb_v_o", wb_v, 1'b0);
      check_value("busy_o", busy, 1'b1);
      @(posedge clk);
    end
    #2;
    flush = 1'b1;
    @(negedge clk);
    check_value("wb_v_o", wb_v, 1'b0); // forced low in flush cycle.
    @(posedge clk);
    #2;
    flush = 1'b0;
    @(negedge clk);
    check_value("busy_o", busy, 1'b0);
    check_value("wb_v_o", wb_v, 1'b0);
  endtask

  task automatic take_packet(input vector_s vec);
    long_pipe_pkg::wb_pkt_s held;
    logic [1:0]             dly;
    @(negedge clk);
    while (wb_v !== 1'b1) begin
      check_value("busy_o", busy, 1'b1);
      @(negedge clk);
    end
    held = wb_pkt;
    check_value("wb_pkt_o.rd_w_v", held.rd_w_v, 1'b1);
    check_value("wb_pkt_o.rd_addr", held.rd_addr, vec.rd_addr);
    check_value("wb_pkt_o.rd_data", held.rd_data, vec.exp_data);
    draw_yumi_delay(dly);
    repeat (dly) begin
      @(negedge clk); // packet must hold under back-pressure.
      check_value("wb_v_o", wb_v, 1'b1);
      check_value("wb_pkt_o", wb_pkt, held);
      check_value("busy_o", busy, 1'b1);
    end
    @(posedge clk);
    #2;
    wb_yumi = 1'b1;
    @(negedge clk);
    check_value("wb_v_o", wb_v, 1'b1);
    check_value("wb_pkt_o", wb_pkt, held);
    check_value("busy_o", busy, 1'b1);
    @(posedge clk);
    #2;
    wb_yumi = 1'b0;
    @(negedge clk);
    check_value("busy_o", busy, 1'b0);
    check_value("wb_v_o", wb_v, 1'b0);
  endtask

  task automatic run_op(input vector_s vec);
    @(posedge clk);
    #2;
    reservation = '{v: 1'b1, op: vec.op, rd_addr: vec.rd_addr,
                    src1: vec.src1, src2: vec.src2};
    @(negedge clk);
    check_value("busy_o", busy, 1'b1);
    @(posedge clk); // accepted here.
    #2;
    reservation.v = 1'b0;
    if (vec.flush_dly != 0) begin
      wait_for_flush(vec);
    end else begin
      take_packet(vec);
    end
  endtask

  initial begin
    arst_n      = 1'b0;
    reservation = '0;
    flush       = 1'b0;
    wb_yumi     = 1'b0;
    lfsr        = 32'he8f78f01;
    load_vectors();
    fork
      watchdog();
    join_none
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    foreach (vectors[i]) begin
      run_op(vectors[i]);
    end
    repeat (2) @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== dv/long_pipe_input.txt ====
// op rd src1 src2 flush expected, all hex. op 0..6 = mulh mulhsu mulhu div divu rem remu
// flush counts cycles from acceptance to flush_i, 00 runs the op to writeback
0 01 00000007 00000003 00 00000000
0 02 80000000 80000000 00 40000000
0 03 ffffffff ffffffff 00 00000000
0 04 80000000 7fffffff 00 c0000000
0 05 12345678 00010000 00 00001234
0 06 fffffffe 00000003 00 ffffffff
1 07 ffffffff ffffffff 00 ffffffff
1 08 80000000 80000000 00 c0000000
1 09 7fffffff ffffffff 00 7ffffffe
2 0a ffffffff ffffffff 00 fffffffe
2 0b 80000000 00000002 00 00000001
2 0c 80000001 80000001 00 40000001
3 0d 00000064 00000007 01 00000000
3 0e 00000014 00000006 00 00000003
3 0f ffffffec 00000006 00 fffffffd
3 10 00000014 fffffffa 00 fffffffd
3 11 ffffffec fffffffa 00 00000003
0 12 7fffffff 7fffffff 14 00000000
3 13 80000000 ffffffff 00 80000000
3 14 00001234 00000000 00 ffffffff
4 15 ffffffec 00000006 00 2aaaaaa7
4 16 12345678 00000000 00 ffffffff
4 17 80000000 ffffffff 00 00000000
5 18 00001234 00000000 01 00000000
5 19 00000014 00000006 00 00000002
5 1a ffffffec 00000006 00 fffffffe
5 1b 00000014 fffffffa 00 00000002
5 1c ffffffec fffffffa 00 fffffffe
4 1d ffffffff 00000003 1e 00000000
5 1e 80000000 ffffffff 00 00000000
5 1f 00001234 00000000 00 00001234
6 01 ffffffec 00000006 00 00000002
6 02 12345678 00000000 00 12345678
6 03 00000064 00000007 00 00000002

// ==== flist.f ====
+incdir+common
common/long_pipe_pkg.sv
verilog/long_pipe_ctrl.sv
muldiv/imul_iterative.sv
muldiv/idiv_iterative.sv
verilog/long_pipe_top.sv
dv/long_pipe_tb.sv
